//--- build.f
cfi_pkg.sv
commit_decoder.sv
return_stack.sv
shadow_stack_checker.sv
landing_pad_checker.sv
cfi_fault_reporter.sv
cfi_monitor.sv
tb_cfi_monitor.sv

//--- tb_cfi_monitor.sv
////////////////////////////////////////
// testbench of the CFI monitor
// instruction-driving tasks, compare tasks, fault watcher
// directed tests for both checkers and a cycle limit
////////////////////////////////////////
module tb_cfi_monitor;
    import cfi_pkg::*;

    localparam int NUM_TESTS    = 9;
    // the overflow test retires two instructions per call and per return
    localparam int OVERFLOW_LEN = 4 * (SS_DEPTH + 3) + 16;
    localparam int CYCLE_LIMIT  = NUM_TESTS * 40 + OVERFLOW_LEN;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    logic       commit_valid_i;
    pc_t        commit_pc_i;
    op_t        commit_op_i;
    reg_addr_t  commit_rd_i;
    reg_addr_t  commit_rs1_i;
    imm_t       commit_imm_i;
    logic       commit_ex_i;
    logic       csr_en_i;
    arg_count_t indirect_args_i;
    logic       fault_valid_o;
    cause_t     fault_cause_o;
    pc_t        fault_tval_o;
    logic       clear_args_o;

    int          cycle = 0;
    int          last_commit_cycle;
    int          errors = 0;
    int          start_errors;
    int          tests_run = 0;
    int          tests_passed = 0;
    int          clear_count;
    int          stale_count;
    int unsigned seed_val;

    // every fault pulse seen since the last test started
    cause_t fault_cause_q[$];
    pc_t    fault_tval_q[$];
    int     fault_cycle_q[$];

    cfi_monitor cfi_monitor_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .commit_valid_i  (commit_valid_i),
        .commit_pc_i     (commit_pc_i),
        .commit_op_i     (commit_op_i),
        .commit_rd_i     (commit_rd_i),
        .commit_rs1_i    (commit_rs1_i),
        .commit_imm_i    (commit_imm_i),
        .commit_ex_i     (commit_ex_i),
        .csr_en_i        (csr_en_i),
        .indirect_args_i (indirect_args_i),
        .fault_valid_o   (fault_valid_o),
        .fault_cause_o   (fault_cause_o),
        .fault_tval_o    (fault_tval_o),
        .clear_args_o    (clear_args_o)
    );

    always #5 clk_i = ~clk_i;

    // the cycle count also bounds the whole run
    always @(posedge clk_i) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////////////////////////
    // fault watcher
    ////////////////////////////////////////

    // outputs are sampled on the falling edge, half a cycle after they settle
    always @(negedge clk_i) begin
        if (rst_ni && fault_valid_o) begin
            fault_cause_q.push_back(fault_cause_o);
            fault_tval_q.push_back(fault_tval_o);
            fault_cycle_q.push_back(cycle);
        end
        if (rst_ni && clear_args_o) begin
            clear_count++;
        end
        // without a fault the cause and tval must read zero
        if (rst_ni && !fault_valid_o && (fault_cause_o != CAUSE_NONE || fault_tval_o != '0)) begin
            stale_count++;
        end
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic report_error(input string name, input string msg);
        $display("ERROR %s: %s", name, msg);
        errors++;
    endtask

    task automatic compare_cause(input string name, input cause_t exp, input cause_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: fault_cause_o expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_pc(input string name, input pc_t exp, input pc_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: fault_tval_o expected %08h, actual %08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input string what,
                               input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s: %s expected %b, actual %b", name, what, exp, act);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // word aligned and kept well below the top of the address space
    function automatic pc_t random_pc();
        pc_t pc;
        pc = $urandom();
        pc[1:0]   = 2'b00;
        pc[31:24] = 8'h10;
        return pc;
    endfunction

    // pad encoding is tag in bits 1:0, count in 10:2, variadic flag in bit 11
    function automatic imm_t pad_imm(input arg_count_t args, input logic variadic);
        imm_t imm;
        imm = '0;
        imm[PAD_TAG_MSB:PAD_TAG_LSB] = PAD_TAG;
        imm[ARGS_MSB:ARGS_LSB]       = args;
        imm[VARIADIC_BIT]            = variadic;
        return imm;
    endfunction

    task automatic retire_instr(input pc_t pc, input op_t op, input reg_addr_t rd,
                                input reg_addr_t rs1, input imm_t imm, input logic ex);
        @(posedge clk_i);
        #1;
        commit_valid_i    = 1'b1;
        commit_pc_i       = pc;
        commit_op_i       = op;
        commit_rd_i       = rd;
        commit_rs1_i      = rs1;
        commit_imm_i      = imm;
        commit_ex_i       = ex;
        last_commit_cycle = cycle;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
            commit_valid_i = 1'b0;
            commit_ex_i    = 1'b0;
        end
    endtask

    // an indirect call jumps through t1, a direct one is a jal, both link in ra
    task automatic call_at(input pc_t pc, input logic indirect, input logic ex);
        if (indirect) begin
            retire_instr(pc, OP_JALR, REG_RA, 5'd6, 12'h0, ex);
        end else begin
            retire_instr(pc, OP_JAL, REG_RA, REG_ZERO, 12'h0, ex);
        end
    endtask

    task automatic ret_at(input pc_t pc, input logic ex);
        retire_instr(pc, OP_JALR, REG_ZERO, REG_RA, 12'h0, ex);
    endtask

    task automatic pad_at(input pc_t pc, input arg_count_t args, input logic variadic);
        retire_instr(pc, OP_ADD, REG_ZERO, REG_ZERO, pad_imm(args, variadic), 1'b0);
    endtask

    task automatic plain_at(input pc_t pc);
        retire_instr(pc, 4'h0, 5'd10, 5'd11, 12'h0, 1'b0);
    endtask

    // each test starts from reset with the monitor enabled and no count announced
    task automatic begin_test();
        rst_ni          = 1'b0;
        commit_valid_i  = 1'b0;
        commit_ex_i     = 1'b0;
        csr_en_i        = 1'b1;
        indirect_args_i = ARGS_UNKNOWN;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        fault_cause_q.delete();
        fault_tval_q.delete();
        fault_cycle_q.delete();
        clear_count  = 0;
        stale_count  = 0;
        start_errors = errors;
    endtask

    // a negative clear count means the pulses are not counted
    task automatic end_test(input string name, input logic exp_fault, input cause_t exp_cause,
                            input pc_t exp_tval, input int exp_cycle, input int exp_clears);
        idle_cycles(8);
        compare_bit(name, "fault_valid_o", exp_fault, fault_cause_q.size() != 0);
        if (exp_fault && fault_cause_q.size() > 1) begin
            report_error(name, $sformatf("%0d fault pulses seen, expected one",
                                         fault_cause_q.size()));
        end
        if (exp_fault && fault_cause_q.size() != 0) begin
            compare_cause(name, exp_cause, fault_cause_q[0]);
            compare_pc(name, exp_tval, fault_tval_q[0]);
            if (fault_cycle_q[0] != exp_cycle) begin
                report_error(name, $sformatf("fault came %0d cycles after the commit, not 3",
                                             fault_cycle_q[0] - exp_cycle + 3));
            end
        end
        if (exp_clears >= 0 && clear_count != exp_clears) begin
            report_error(name, $sformatf("clear_args_o pulsed %0d times, expected %0d",
                                         clear_count, exp_clears));
        end
        if (stale_count != 0) begin
            report_error(name, "fault cause or tval was nonzero without a fault");
        end
        tests_run++;
        if (errors == start_errors) begin
            tests_passed++;
            $display("test %-20s ok", name);
        end else begin
            $display("test %-20s FAILED", name);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_direct_call_return();
        pc_t c;
        pc_t p;
        pc_t r;
        begin_test();
        compare_bit("direct_call_return", "fault_valid_o after reset", 1'b0, fault_valid_o);
        compare_bit("direct_call_return", "clear_args_o after reset", 1'b0, clear_args_o);
        c = random_pc();
        p = c + 32'h400;
        r = p + 32'h10;
        call_at(c, 1'b0, 1'b0);
        pad_at(p, arg_count_t'($urandom_range(0, 300)), 1'b0);
        plain_at(p + 32'd4);
        ret_at(r, 1'b0);
        plain_at(c + 32'd4);
        end_test("direct_call_return", 1'b0, CAUSE_NONE, '0, 0, 1);
    endtask

    task automatic test_missing_pad();
        pc_t c;
        begin_test();
        c = random_pc();
        call_at(c, 1'b0, 1'b0);
        plain_at(c + 32'h100);
        end_test("missing_pad", 1'b1, CAUSE_LANDING_FAULT, c, last_commit_cycle + 3, 1);
    endtask

    task automatic test_arg_mismatch();
        pc_t        c;
        arg_count_t n;
        begin_test();
        c = random_pc();
        n = arg_count_t'($urandom_range(1, 200));
        indirect_args_i = n;
        call_at(c, 1'b1, 1'b0);
        pad_at(c + 32'h200, arg_count_t'(n + 1), 1'b0);
        end_test("arg_mismatch", 1'b1, CAUSE_LANDING_FAULT, c, last_commit_cycle + 3, 1);
    endtask

    // a variadic function may receive more arguments than it declares
    task automatic test_variadic_pad();
        pc_t        c;
        arg_count_t n;
        begin_test();
        c = random_pc();
        n = arg_count_t'($urandom_range(1, 200));
        indirect_args_i = n;
        call_at(c, 1'b1, 1'b0);
        pad_at(c + 32'h200, arg_count_t'(n + $urandom_range(0, 50)), 1'b1);
        end_test("variadic_pad", 1'b0, CAUSE_NONE, '0, 0, 1);
    endtask

    task automatic test_unknown_args();
        pc_t c;
        begin_test();
        c = random_pc();
        call_at(c, 1'b1, 1'b0);
        pad_at(c + 32'h200, arg_count_t'($urandom_range(0, 510)), 1'b0);
        end_test("unknown_args", 1'b0, CAUSE_NONE, '0, 0, 1);
    endtask

    task automatic test_bad_return();
        pc_t c;
        pc_t r;
        begin_test();
        c = random_pc();
        r = c + 32'h800;
        call_at(c, 1'b0, 1'b0);
        pad_at(c + 32'h40, 9'd0, 1'b0);
        ret_at(r, 1'b0);
        plain_at(c + 32'd12);
        end_test("bad_return", 1'b1, CAUSE_RETURN_FAULT, r, last_commit_cycle + 3, -1);
    endtask

    task automatic test_overflow();
        pc_t base;
        pc_t ret_base;
        pc_t c;
        pc_t r;
        int  i;
        begin_test();
        base     = random_pc();
        ret_base = base + 32'h4000;
        for (i = 0; i < SS_DEPTH + 3; i++) begin
            call_at(base + pc_t'(i * 64), 1'b0, 1'b0);
            pad_at(base + pc_t'(i * 64) + 32'h20, 9'd0, 1'b0);
        end
        // the three deepest calls were never stored, so their returns go unchecked
        for (i = SS_DEPTH + 2; i >= 0; i--) begin
            ret_at(ret_base + pc_t'(i * 16), 1'b0);
            if (i >= SS_DEPTH) begin
                plain_at(base + pc_t'(i * 64) + 32'd8);
            end else begin
                plain_at(base + pc_t'(i * 64) + 32'd4);
            end
        end
        // back in range, a wrong return is caught again
        c = base + 32'h8000;
        r = c + 32'h100;
        call_at(c, 1'b0, 1'b0);
        pad_at(c + 32'h40, 9'd0, 1'b0);
        ret_at(r, 1'b0);
        plain_at(c + 32'd12);
        end_test("overflow", 1'b1, CAUSE_RETURN_FAULT, r, last_commit_cycle + 3, -1);
    endtask

    task automatic test_disabled();
        pc_t c;
        pc_t r;
        begin_test();
        c = random_pc();
        r = c + 32'h800;
        // one stored address, so the return below would be wrong if checked
        call_at(c, 1'b0, 1'b0);
        pad_at(c + 32'h40, 9'd0, 1'b0);
        idle_cycles(3);
        csr_en_i = 1'b0;
        idle_cycles(2);
        compare_bit("disabled", "clear_args_o", 1'b1, clear_args_o);
        call_at(c + 32'h1000, 1'b0, 1'b0);
        compare_bit("disabled", "clear_args_o", 1'b1, clear_args_o);
        plain_at(c + 32'h2000);
        compare_bit("disabled", "clear_args_o", 1'b1, clear_args_o);
        ret_at(r, 1'b0);
        compare_bit("disabled", "clear_args_o", 1'b1, clear_args_o);
        plain_at(c + 32'd12);
        compare_bit("disabled", "clear_args_o", 1'b1, clear_args_o);
        end_test("disabled", 1'b0, CAUSE_NONE, '0, 0, -1);
    endtask

    task automatic test_excepted();
        pc_t c;
        pc_t r;
        begin_test();
        c = random_pc();
        r = c + 32'h800;
        // a trapped call arms nothing
        call_at(c, 1'b0, 1'b1);
        plain_at(c + 32'h100);
        // a trapped return pops nothing and its target goes unchecked
        call_at(c + 32'h200, 1'b0, 1'b0);
        pad_at(c + 32'h240, 9'd0, 1'b0);
        ret_at(r, 1'b1);
        plain_at(c + 32'h300);
        end_test("excepted", 1'b0, CAUSE_NONE, '0, 0, 1);
    endtask

    initial begin
        rst_ni          = 1'b0;
        commit_valid_i  = 1'b0;
        commit_pc_i     = '0;
        commit_op_i     = '0;
        commit_rd_i     = '0;
        commit_rs1_i    = '0;
        commit_imm_i    = '0;
        commit_ex_i     = 1'b0;
        csr_en_i        = 1'b1;
        indirect_args_i = ARGS_UNKNOWN;
        clear_count     = 0;
        stale_count     = 0;
        seed_val        = $urandom(32'h9860);

        test_direct_call_return();
        test_missing_pad();
        test_arg_mismatch();
        test_variadic_pad();
        test_unknown_args();
        test_bad_return();
        test_overflow();
        test_disabled();
        test_excepted();

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- cfi_monitor.sv
////////////////////////////////////////
// top level of the CFI monitor
// decoder, return and landing-pad checkers, fault reporter
////////////////////////////////////////
module cfi_monitor (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                commit_valid_i,
    input  cfi_pkg::pc_t        commit_pc_i,
    input  cfi_pkg::op_t        commit_op_i,
    input  cfi_pkg::reg_addr_t  commit_rd_i,
    input  cfi_pkg::reg_addr_t  commit_rs1_i,
    input  cfi_pkg::imm_t       commit_imm_i,
    input  logic                commit_ex_i,
    input  logic                csr_en_i,
    input  cfi_pkg::arg_count_t indirect_args_i,
    output logic                fault_valid_o,
    output cfi_pkg::cause_t     fault_cause_o,
    output cfi_pkg::pc_t        fault_tval_o,
    output logic                clear_args_o
);
    import cfi_pkg::*;

    // decoded event, shared by both checkers
    logic       ev_valid;
    logic       ev_call;
    logic       ev_ret;
    logic       ev_pad;
    logic       ev_variadic;
    arg_count_t ev_args;
    pc_t        ev_pc;

    // verdicts
    logic       ret_fault;
    pc_t        ret_pc;
    logic       pad_fault;
    pc_t        call_pc;

    commit_decoder commit_decoder_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .commit_valid_i (commit_valid_i),
        .commit_pc_i    (commit_pc_i),
        .commit_op_i    (commit_op_i),
        .commit_rd_i    (commit_rd_i),
        .commit_rs1_i   (commit_rs1_i),
        .commit_imm_i   (commit_imm_i),
        .commit_ex_i    (commit_ex_i),
        .ev_valid_o     (ev_valid),
        .ev_call_o      (ev_call),
        .ev_ret_o       (ev_ret),
        .ev_pad_o       (ev_pad),
        .ev_variadic_o  (ev_variadic),
        .ev_args_o      (ev_args),
        .ev_pc_o        (ev_pc)
    );

    shadow_stack_checker shadow_stack_checker_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .csr_en_i    (csr_en_i),
        .ev_valid_i  (ev_valid),
        .ev_call_i   (ev_call),
        .ev_ret_i    (ev_ret),
        .ev_pc_i     (ev_pc),
        .ret_fault_o (ret_fault),
        .ret_pc_o    (ret_pc)
    );

    landing_pad_checker landing_pad_checker_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .csr_en_i        (csr_en_i),
        .indirect_args_i (indirect_args_i),
        .ev_valid_i      (ev_valid),
        .ev_call_i       (ev_call),
        .ev_pad_i        (ev_pad),
        .ev_variadic_i   (ev_variadic),
        .ev_args_i       (ev_args),
        .ev_pc_i         (ev_pc),
        .pad_fault_o     (pad_fault),
        .call_pc_o       (call_pc),
        .clear_args_o    (clear_args_o)
    );

    cfi_fault_reporter cfi_fault_reporter_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .ret_fault_i   (ret_fault),
        .ret_pc_i      (ret_pc),
        .pad_fault_i   (pad_fault),
        .call_pc_i     (call_pc),
        .fault_valid_o (fault_valid_o),
        .fault_cause_o (fault_cause_o),
        .fault_tval_o  (fault_tval_o)
    );

endmodule

//--- cfi_fault_reporter.sv
////////////////////////////////////////
// fault reporter of the CFI monitor
////////////////////////////////////////
module cfi_fault_reporter (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           ret_fault_i,
    input  cfi_pkg::pc_t   ret_pc_i,
    input  logic           pad_fault_i,
    input  cfi_pkg::pc_t   call_pc_i,
    output logic           fault_valid_o,
    output cfi_pkg::cause_t fault_cause_o,
    output cfi_pkg::pc_t   fault_tval_o
);
    import cfi_pkg::*;

    cause_t cause_d;
    pc_t    tval_d;

    // a broken return wins over a missing pad in the same cycle
    always_comb begin
        cause_d = CAUSE_NONE;
        tval_d  = '0;
        if (ret_fault_i) begin
            cause_d = CAUSE_RETURN_FAULT;
            tval_d  = ret_pc_i;
        end else if (pad_fault_i) begin
            cause_d = CAUSE_LANDING_FAULT;
            tval_d  = call_pc_i;
        end
    end

    // cause and tval drop back to zero with the valid bit
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            fault_valid_o <= 1'b0;
            fault_cause_o <= CAUSE_NONE;
            fault_tval_o  <= '0;
        end else begin
            fault_valid_o <= ret_fault_i || pad_fault_i;
            fault_cause_o <= cause_d;
            fault_tval_o  <= tval_d;
        end
    end

endmodule

//--- landing_pad_checker.sv
////////////////////////////////////////
// forward edge check of the CFI monitor
// each call must land on a pad with matching arguments
////////////////////////////////////////
module landing_pad_checker (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                csr_en_i,
    input  cfi_pkg::arg_count_t indirect_args_i,
    input  logic                ev_valid_i,
    input  logic                ev_call_i,
    input  logic                ev_pad_i,
    input  logic                ev_variadic_i,
    input  cfi_pkg::arg_count_t ev_args_i,
    input  cfi_pkg::pc_t        ev_pc_i,
    output logic                pad_fault_o,
    output cfi_pkg::pc_t        call_pc_o,
    output logic                clear_args_o
);
    import cfi_pkg::*;

    pad_state_t state_q;
    pad_state_t state_d;
    logic       arm;
    logic       resolve;
    logic       args_ok;
    logic       pad_ok;
    pc_t        call_pc_q;

    // a direct call leaves the count unknown and any pad is accepted
    // a variadic pad takes at least the announced count, others exactly that count
    always_comb begin
        if (indirect_args_i == ARGS_UNKNOWN) begin
            args_ok = 1'b1;
        end else if (ev_variadic_i) begin
            args_ok = ev_args_i >= indirect_args_i;
        end else begin
            args_ok = ev_args_i == indirect_args_i;
        end
    end

    assign pad_ok = ev_pad_i && args_ok;

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    assign arm     = csr_en_i && ev_valid_i && ev_call_i;
    assign resolve = ev_valid_i && (state_q == AWAIT_PAD);

    // a call right after a call is checked and also arms the next check
    always_comb begin
        state_d = state_q;
        if (arm) begin
            state_d = AWAIT_PAD;
        end else if (resolve) begin
            state_d = PAD_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q      <= PAD_IDLE;
            pad_fault_o  <= 1'b0;
            clear_args_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            pad_fault_o  <= resolve && csr_en_i && !pad_ok;
            // the count register is consumed by each check and held clear when off
            clear_args_o <= resolve || !csr_en_i;
        end
    end

    ////////////////////////////////////////
    // call address
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (arm) begin
            call_pc_q <= ev_pc_i;
        end
    end

    // a fault names the call, not the instruction it landed on
    always_ff @(posedge clk_i) begin
        if (resolve) begin
            call_pc_o <= call_pc_q;
        end
    end

endmodule

//--- shadow_stack_checker.sv
////////////////////////////////////////
// backward edge check of the CFI monitor
// compares the target of each return with the shadow stack
////////////////////////////////////////
module shadow_stack_checker (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         csr_en_i,
    input  logic         ev_valid_i,
    input  logic         ev_call_i,
    input  logic         ev_ret_i,
    input  cfi_pkg::pc_t ev_pc_i,
    output logic         ret_fault_o,
    output cfi_pkg::pc_t ret_pc_o
);
    import cfi_pkg::*;

    ret_state_t state_q;
    ret_state_t state_d;
    logic       push;
    logic       pop;
    logic       arm;
    logic       resolve;
    logic       mismatch;
    pc_t        top_addr;
    logic       top_valid;
    pc_t        tgt_addr_q;
    logic       tgt_valid_q;
    pc_t        ret_pc_q;

    // the stack only moves while the monitor is enabled
    assign push = csr_en_i && ev_valid_i && ev_call_i;
    assign pop  = csr_en_i && ev_valid_i && ev_ret_i;

    return_stack return_stack_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .push_addr_i (ev_pc_i + INSTR_BYTES),
        .pop_i       (pop),
        .top_addr_o  (top_addr),
        .top_valid_o (top_valid)
    );

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    // every enabled return arms the check, even the one that resolves the last
    assign arm     = pop;
    assign resolve = ev_valid_i && (state_q == AWAIT_TARGET);

    always_comb begin
        state_d = state_q;
        if (arm) begin
            state_d = AWAIT_TARGET;
        end else if (resolve) begin
            state_d = RET_IDLE;
        end
    end

    // an address lost to overflow was captured as invalid and is not compared
    assign mismatch = tgt_valid_q && (tgt_addr_q != ev_pc_i);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q     <= RET_IDLE;
            ret_fault_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            ret_fault_o <= resolve && csr_en_i && mismatch;
        end
    end

    ////////////////////////////////////////
    // captured return
    ////////////////////////////////////////

    // the popped address is taken before the pointer moves past it
    always_ff @(posedge clk_i) begin
        if (arm) begin
            tgt_addr_q  <= top_addr;
            tgt_valid_q <= top_valid;
            ret_pc_q    <= ev_pc_i;
        end
    end

    // the reported pc is the return itself and not its target
    always_ff @(posedge clk_i) begin
        if (resolve) begin
            ret_pc_o <= ret_pc_q;
        end
    end

endmodule

//--- return_stack.sv
////////////////////////////////////////
// return address storage of the shadow stack
// the pointer keeps counting after the storage is full
////////////////////////////////////////
module return_stack (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         push_i,
    input  cfi_pkg::pc_t push_addr_i,
    input  logic         pop_i,
    output cfi_pkg::pc_t top_addr_o,
    output logic         top_valid_o
);
    import cfi_pkg::*;

    pc_t                 mem [SS_DEPTH];
    sp_t                 sp_q;
    sp_t                 sp_inc;
    sp_t                 sp_dec;
    logic [SS_IDX_W-1:0] top_idx;
    logic [SS_IDX_W-1:0] wr_idx;
    logic                room;
    logic                sp_max;

    assign sp_inc = sp_q + sp_t'(1);
    assign sp_dec = sp_q - sp_t'(1);

    // the top entry sits one below the pointer, the next free slot at the pointer
    assign top_idx = sp_dec[SS_IDX_W-1:0];
    assign wr_idx  = sp_q[SS_IDX_W-1:0];

    // a push lands in storage only while a free slot is left
    assign room = sp_q < sp_t'(SS_DEPTH);

    // the pointer saturates, nesting deeper than its range is not tracked
    assign sp_max = &sp_q;

    // entries past the depth were never stored, so the top is only trusted in range
    assign top_valid_o = (sp_q != '0) && (sp_q <= sp_t'(SS_DEPTH));
    assign top_addr_o  = mem[top_idx];

    ////////////////////////////////////////
    // stack pointer
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            sp_q <= '0;
        end else if (push_i && !pop_i && !sp_max) begin
            sp_q <= sp_inc;
        end else if (pop_i && !push_i && (sp_q != '0)) begin
            sp_q <= sp_dec;
        end
    end

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // a push together with a pop replaces the top in place
    always_ff @(posedge clk_i) begin
        if (push_i && pop_i) begin
            if (top_valid_o) begin
                mem[top_idx] <= push_addr_i;
            end
        end else if (push_i && room) begin
            mem[wr_idx] <= push_addr_i;
        end
    end

endmodule

//--- commit_decoder.sv
////////////////////////////////////////
// commit decoder of the CFI monitor
// registers and classifies one retired instruction per cycle
////////////////////////////////////////
module commit_decoder (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                commit_valid_i,
    input  cfi_pkg::pc_t        commit_pc_i,
    input  cfi_pkg::op_t        commit_op_i,
    input  cfi_pkg::reg_addr_t  commit_rd_i,
    input  cfi_pkg::reg_addr_t  commit_rs1_i,
    input  cfi_pkg::imm_t       commit_imm_i,
    input  logic                commit_ex_i,
    output logic                ev_valid_o,
    output logic                ev_call_o,
    output logic                ev_ret_o,
    output logic                ev_pad_o,
    output logic                ev_variadic_o,
    output cfi_pkg::arg_count_t ev_args_o,
    output cfi_pkg::pc_t        ev_pc_o
);
    import cfi_pkg::*;

    logic take;
    logic is_call;
    logic is_ret;
    logic is_pad;
    logic link_rd;
    logic link_rs1;

    // instructions that trapped on their own never reach the checkers
    assign take = commit_valid_i && !commit_ex_i;

    // ra and t0 are the two link registers of the calling convention
    assign link_rd  = (commit_rd_i == REG_RA) || (commit_rd_i == REG_T0);
    assign link_rs1 = (commit_rs1_i == REG_RA) || (commit_rs1_i == REG_T0);

    // a jump that writes a link register is a call
    assign is_call = ((commit_op_i == OP_JAL) || (commit_op_i == OP_JALR)) && link_rd;

    // an indirect jump through a link register that discards the link is a return
    assign is_ret = (commit_op_i == OP_JALR) && (commit_rd_i == REG_ZERO) && link_rs1;

    // the landing pad is an add to x0 from x0 with the pad tag in the immediate
    assign is_pad = (commit_op_i == OP_ADD) &&
                    (commit_rd_i == REG_ZERO) &&
                    (commit_rs1_i == REG_ZERO) &&
                    (commit_imm_i[PAD_TAG_MSB:PAD_TAG_LSB] == PAD_TAG);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            ev_valid_o <= 1'b0;
        end else begin
            ev_valid_o <= take;
        end
    end

    // the event payload only means something while ev_valid_o is high
    always_ff @(posedge clk_i) begin
        if (take) begin
            ev_call_o     <= is_call;
            ev_ret_o      <= is_ret;
            ev_pad_o      <= is_pad;
            ev_variadic_o <= commit_imm_i[VARIADIC_BIT];
            ev_args_o     <= commit_imm_i[ARGS_MSB:ARGS_LSB];
            ev_pc_o       <= commit_pc_i;
        end
    end

endmodule

//--- cfi_pkg.sv
////////////////////////////////////////
// widths, opcodes and register numbers of the CFI monitor
// landing-pad field layout, shadow stack depth and fault causes
////////////////////////////////////////
package cfi_pkg;

    ////////////////////////////////////////
    // instruction stream
    ////////////////////////////////////////

    // address width of the retired instruction stream
    localparam int unsigned XLEN = 32;
    typedef logic [XLEN-1:0] pc_t;

    // functional opcode as reported by the commit stage
    typedef logic [3:0] op_t;
    localparam op_t OP_ADD  = 4'h1;
    localparam op_t OP_JAL  = 4'h2;
    localparam op_t OP_JALR = 4'h3;

    // architectural register numbers
    typedef logic [4:0] reg_addr_t;
    localparam reg_addr_t REG_ZERO = 5'd0;
    localparam reg_addr_t REG_RA   = 5'd1;
    localparam reg_addr_t REG_T0   = 5'd5;

    // immediate field, which carries the landing-pad encoding
    typedef logic [11:0] imm_t;

    // every instruction is 4 bytes, so a call returns to pc + 4
    localparam pc_t INSTR_BYTES = 32'd4;

    ////////////////////////////////////////
    // landing pad
    ////////////////////////////////////////

    // the two low bits tag the no-op as a landing pad
    localparam int unsigned PAD_TAG_LSB = 0;
    localparam int unsigned PAD_TAG_MSB = 1;
    localparam logic [PAD_TAG_MSB:PAD_TAG_LSB] PAD_TAG = 2'd2;

    // declared argument count of the function behind the pad
    localparam int unsigned ARGS_LSB = 2;
    localparam int unsigned ARGS_MSB = 10;
    typedef logic [ARGS_MSB-ARGS_LSB:0] arg_count_t;

    // set when the function takes a variable number of arguments
    localparam int unsigned VARIADIC_BIT = 11;

    // all ones means the last call was direct and no count was announced
    localparam arg_count_t ARGS_UNKNOWN = '1;

    ////////////////////////////////////////
    // shadow stack
    ////////////////////////////////////////

    localparam int unsigned SS_DEPTH = 16;
    localparam int unsigned SS_IDX_W = $clog2(SS_DEPTH);

    // two extra bits let the pointer count well past the storage depth
    typedef logic [SS_IDX_W+1:0] sp_t;

    ////////////////////////////////////////
    // faults and state machines
    ////////////////////////////////////////

    // cause codes follow the RISC-V access fault numbering
    typedef logic [3:0] cause_t;
    localparam cause_t CAUSE_NONE          = 4'd0;
    localparam cause_t CAUSE_RETURN_FAULT  = 4'd1;
    localparam cause_t CAUSE_LANDING_FAULT = 4'd5;

    // enum literals share the package scope, hence the prefixed idle states
    typedef enum logic {
        PAD_IDLE,
        AWAIT_PAD
    } pad_state_t;

    typedef enum logic {
        RET_IDLE,
        AWAIT_TARGET
    } ret_state_t;

endpackage
